// ==== icache_victim_buffer.f ====
logic/victim_pkg.sv
logic/victim_entry.sv
logic/victim_alloc.sv
logic/victim_lookup.sv
logic/icache_victim_buffer.sv
sim/tb_icache_victim_buffer.sv

// ==== logic/icache_victim_buffer.sv ====
`timescale 1ns/10ps

module icache_victim_buffer
    import victim_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    // line evicted from the cache.
    input  logic  evict_valid,
    input  addr_t evict_address,
    input  line_t evict_line,

    // fetch side.
    input  logic  lookup_valid,
    input  addr_t mem_address,
    input  logic  take,

    output logic  hit,
    output way_t  hit_way,
    output line_t data_to_cache
);

    tag_t                      evict_tag;
    tag_t                      lookup_tag;

    logic [VICTIM_ENTRIES-1:0] entry_valid;
    logic [VICTIM_ENTRIES-1:0] entry_match;
    line_t                     entry_line [VICTIM_ENTRIES];
    logic [VICTIM_ENTRIES-1:0] entry_load;
    logic [VICTIM_ENTRIES-1:0] entry_clear;

    assign evict_tag  = evict_address[ADDR_WIDTH-1:TAG_LSB];
    assign lookup_tag = mem_address[ADDR_WIDTH-1:TAG_LSB]; // offset bits are ignored.

    victim_alloc u_alloc (
        .clk          (clk),
        .rst          (rst),
        .evict_valid  (evict_valid),
        .take         (take),
        .lookup_valid (lookup_valid),
        .hit          (hit),
        .hit_way      (hit_way),
        .valid        (entry_valid),
        .load         (entry_load),
        .clear        (entry_clear)
    );

    for (genvar i = 0; i < VICTIM_ENTRIES; i++) begin : g_entry
        victim_entry u_entry (
            .clk        (clk),
            .rst        (rst),
            .load       (entry_load[i]),
            .clear      (entry_clear[i]),
            .tag_in     (evict_tag),
            .line_in    (evict_line),
            .lookup_tag (lookup_tag),
            .valid      (entry_valid[i]),
            .match      (entry_match[i]),
            .line       (entry_line[i])
        );
    end

    victim_lookup u_lookup (
        .clk           (clk),
        .rst           (rst),
        .lookup_valid  (lookup_valid),
        .match         (entry_match),
        .line          (entry_line),
        .hit           (hit),
        .hit_way       (hit_way),
        .data_to_cache (data_to_cache)
    );

endmodule : icache_victim_buffer

// ==== logic/victim_alloc.sv ====
`timescale 1ns/10ps

module victim_alloc
    import victim_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      evict_valid,
    input  logic                      take,
    input  logic                      lookup_valid,
    input  logic                      hit,
    input  way_t                      hit_way,
    input  logic [VICTIM_ENTRIES-1:0] valid,

    output logic [VICTIM_ENTRIES-1:0] load,
    output logic [VICTIM_ENTRIES-1:0] clear
);

    way_t lru;          // the entry to replace when both are full.
    way_t free_way;
    way_t target;
    logic has_free;
    logic swap;

    assign swap = take && hit;

    // lowest invalid entry. Walking down leaves the lowest one last.
    always_comb begin
        has_free = 1'b0;
        free_way = '0;
        for (int i = VICTIM_ENTRIES - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                has_free = 1'b1;
                free_way = way_t'(i);
            end
        end
    end

    always_comb begin
        if (swap) begin
            target = hit_way; // true swap into the entry being taken.
        end else if (has_free) begin
            target = free_way;
        end else begin
            target = lru;
        end
    end

    always_comb begin
        load  = '0;
        clear = '0;
        if (evict_valid) begin
            load[target] = 1'b1;
        end else if (swap) begin
            clear[hit_way] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lru <= '0;
        end else if (evict_valid) begin
            lru <= ~target;
        end else if (swap) begin
            lru <= hit_way; // the freed entry is the next one to fill.
        end else if (lookup_valid && hit) begin
            lru <= ~hit_way;
        end
    end

    a_load_onehot0 : assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(load)
    ) else $error("victim_alloc: more than one entry loaded");

    // the fetch unit may only take a line that hit this cycle.
    a_take_needs_hit : assert property (
        @(posedge clk) disable iff (rst)
        take |-> hit
    ) else $error("victim_alloc: take without hit");

endmodule : victim_alloc

// ==== logic/victim_entry.sv ====
`timescale 1ns/10ps

module victim_entry
    import victim_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  load,
    input  logic  clear,
    input  tag_t  tag_in,
    input  line_t line_in,

    input  tag_t  lookup_tag,

    output logic  valid,
    output logic  match,
    output line_t line
);

    tag_t tag_q;

    // load wins over clear, though the allocator never asks for both.
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= 1'b1;
        end else if (clear) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            tag_q <= tag_in;
            line  <= line_in; // the line is read out by the lookup side.
        end
    end

    // an empty entry never matches, whatever its stale tag holds.
    assign match = valid && (tag_q == lookup_tag);

    // a swap goes through load alone. The freed entry is simply reused.
    a_no_load_and_clear : assert property (
        @(posedge clk) disable iff (rst)
        !(load && clear)
    ) else $error("victim_entry: load and clear both high");

endmodule : victim_entry

// ==== logic/victim_lookup.sv ====
`timescale 1ns/10ps

module victim_lookup
    import victim_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      lookup_valid,
    input  logic [VICTIM_ENTRIES-1:0] match,
    input  line_t                     line [VICTIM_ENTRIES],

    output logic                      hit,
    output way_t                      hit_way,
    output line_t                     data_to_cache
);

    logic [VICTIM_ENTRIES-1:0] match_qual;

    // entries compare every cycle. Only a real fetch counts.
    assign match_qual = match & {VICTIM_ENTRIES{lookup_valid}};

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < VICTIM_ENTRIES; i++) begin
            if (match_qual[i]) begin
                hit     = 1'b1;
                hit_way = way_t'(i);
            end
        end
    end

    // misses leave the last returned line in place.
    always_ff @(posedge clk) begin
        if (rst) begin
            data_to_cache <= '0;
        end else if (hit) begin
            data_to_cache <= line[hit_way];
        end
    end

    // two entries holding the same tag would mean the allocator inserted
    // a line that was already buffered.
    a_match_onehot0 : assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(match)
    ) else $error("victim_lookup: tag matched in more than one entry");

endmodule : victim_lookup

// ==== logic/victim_pkg.sv ====
package victim_pkg;

    // address and line geometry of the instruction cache.
    localparam int ADDR_WIDTH = 32;
    localparam int LINE_WIDTH = 256;
    localparam int TAG_LSB    = 5;   // a line covers 32 bytes.
    localparam int TAG_WIDTH  = ADDR_WIDTH - TAG_LSB;

    // the LRU rule in victim_alloc only holds for two entries.
    localparam int VICTIM_ENTRIES = 2;
    localparam int WAY_WIDTH      = $clog2(VICTIM_ENTRIES);

    // fetch or evict byte address.
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // line tag, address bits 31 down to 5.
    typedef logic [TAG_WIDTH-1:0] tag_t;

    // one full cache line.
    typedef logic [LINE_WIDTH-1:0] line_t;

    // index of a buffer entry.
    typedef logic [WAY_WIDTH-1:0] way_t;

endpackage : victim_pkg

// ==== run_sim.sh ====
#!/bin/sh
# Compiles the victim buffer testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

TOP=tb_icache_victim_buffer
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module "$TOP" -f icache_victim_buffer.f -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the verdict comes from the log, not from the exit status alone.
if grep -qx "RESULT: PASS" "$LOG"; then
    echo "simulation passed"
    exit 0
fi

echo "pass message not found in $LOG"
exit 1

// ==== sim/tb_icache_victim_buffer.sv ====
`timescale 1ns/10ps

module tb_icache_victim_buffer
    import victim_pkg::*;
();

    localparam int CYCLE_LIMIT = 600; // the tests need about 300 cycles.

    logic  clk;
    logic  rst;
    logic  evict_valid;
    addr_t evict_address;
    line_t evict_line;
    logic  lookup_valid;
    addr_t mem_address;
    logic  take;
    logic  hit;
    way_t  hit_way;
    line_t data_to_cache;

    // reference model of the two entries and the replacement bit.
    logic  ref_valid [VICTIM_ENTRIES];
    tag_t  ref_tag   [VICTIM_ENTRIES];
    line_t ref_line  [VICTIM_ENTRIES];
    way_t  ref_lru;
    line_t ref_data;
    logic  exp_hit;
    way_t  exp_way;
    int    cycles;

    icache_victim_buffer dut (
        .clk           (clk),
        .rst           (rst),
        .evict_valid   (evict_valid),
        .evict_address (evict_address),
        .evict_line    (evict_line),
        .lookup_valid  (lookup_valid),
        .mem_address   (mem_address),
        .take          (take),
        .hit           (hit),
        .hit_way       (hit_way),
        .data_to_cache (data_to_cache)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always_comb begin
        exp_hit = 1'b0;
        exp_way = 1'b0;
        if (lookup_valid && ref_valid[1] && ref_tag[1] == mem_address[ADDR_WIDTH-1:TAG_LSB]) begin
            exp_hit = 1'b1;
            exp_way = 1'b1;
        end
        if (lookup_valid && ref_valid[0] && ref_tag[0] == mem_address[ADDR_WIDTH-1:TAG_LSB]) begin
            exp_hit = 1'b1;
            exp_way = 1'b0;
        end
    end

    always @(posedge clk) begin
        way_t target;
        if (rst) begin
            ref_valid[0] <= 1'b0;
            ref_valid[1] <= 1'b0;
            ref_lru      <= 1'b0;
            ref_data     <= '0;
        end else begin
            if (exp_hit) begin
                ref_data <= ref_line[exp_way]; // the old line, even if it is replaced now.
            end
            if (evict_valid) begin
                if (take && exp_hit) begin
                    target = exp_way;
                end else if (!ref_valid[0]) begin
                    target = 1'b0;
                end else if (!ref_valid[1]) begin
                    target = 1'b1;
                end else begin
                    target = ref_lru;
                end
                ref_valid[target] <= 1'b1;
                ref_tag[target]   <= evict_address[ADDR_WIDTH-1:TAG_LSB];
                ref_line[target]  <= evict_line;
                ref_lru           <= ~target;
            end else if (take && exp_hit) begin
                ref_valid[exp_way] <= 1'b0;
                ref_lru            <= exp_way;
            end else if (exp_hit) begin
                ref_lru <= ~exp_way;
            end
        end
    end

    a_hit : assert property (@(posedge clk) disable iff (rst) hit == exp_hit)
        else begin
            $display("[ERROR] hit: got %h, expected %h", $sampled(hit), $sampled(exp_hit));
            $display("RESULT: FAIL");
            $fatal(1, "hit mismatch");
        end

    a_hit_way : assert property (@(posedge clk) disable iff (rst) exp_hit |-> hit_way == exp_way)
        else begin
            $display("[ERROR] hit_way: got %h, expected %h", $sampled(hit_way),
                     $sampled(exp_way));
            $display("RESULT: FAIL");
            $fatal(1, "hit_way mismatch");
        end

    // holds on misses too, so an unchanged line is checked every cycle.
    a_data : assert property (@(posedge clk) disable iff (rst) data_to_cache == ref_data)
        else begin
            $display("[ERROR] data_to_cache: got %h, expected %h", $sampled(data_to_cache),
                     $sampled(ref_data));
            $display("RESULT: FAIL");
            $fatal(1, "data_to_cache mismatch");
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic insert(input addr_t address, input line_t data);
        evict_valid   = 1'b1;
        evict_address = address;
        evict_line    = data;
        tick();
        evict_valid   = 1'b0;
    endtask

    task automatic fetch(input addr_t address, input logic take_it);
        lookup_valid = 1'b1;
        mem_address  = address;
        take         = take_it;
        tick();
        lookup_valid = 1'b0;
        take         = 1'b0;
    endtask

    // a hit fetch and an evict in the same cycle, a swap when take_it is set.
    task automatic evict_and_fetch(input addr_t fetched, input logic take_it,
                                   input addr_t address, input line_t data);
        lookup_valid  = 1'b1;
        mem_address   = fetched;
        take          = take_it;
        evict_valid   = 1'b1;
        evict_address = address;
        evict_line    = data;
        tick();
        lookup_valid  = 1'b0;
        take          = 1'b0;
        evict_valid   = 1'b0;
    endtask

    function automatic line_t random_line();
        line_t data;
        for (int i = 0; i < LINE_WIDTH / 32; i++) begin
            data[i*32 +: 32] = $urandom;
        end
        return data;
    endfunction

    // an address whose tag is in no valid entry.
    function automatic addr_t fresh_address();
        addr_t address;
        logic  used;
        do begin
            address = $urandom;
            used    = 1'b0;
            for (int i = 0; i < VICTIM_ENTRIES; i++) begin
                if (ref_valid[i] && ref_tag[i] == address[ADDR_WIDTH-1:TAG_LSB]) begin
                    used = 1'b1;
                end
            end
        end while (used);
        return address;
    endfunction

    function automatic addr_t stored_address(input way_t w);
        logic [31:0] offset;
        offset = $urandom;
        return {ref_tag[w], offset[TAG_LSB-1:0]};
    endfunction

    initial begin
        addr_t addr [6];
        way_t  w;
        int    op;
        void'($urandom(24516));
        rst           = 1'b1;
        evict_valid   = 1'b0;
        evict_address = '0;
        evict_line    = '0;
        lookup_valid  = 1'b0;
        mem_address   = '0;
        take          = 1'b0;
        cycles        = 0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int i = 0; i < 4; i++) begin
            fetch(fresh_address(), 1'b0); // empty buffer, all misses.
        end

        addr[0] = fresh_address();
        insert(addr[0], random_line());
        fetch(addr[0], 1'b0);
        tick();
        fetch(addr[0] ^ 32'h1c, 1'b0);

        addr[1] = fresh_address();
        insert(addr[1], random_line());
        addr[2] = fresh_address();
        insert(addr[2], random_line()); // both full, so this one replaces a line.
        fetch(addr[0], 1'b0);
        fetch(addr[2], 1'b0);
        fetch(addr[1], 1'b0); // hitting way 1 last makes way 0 the one to replace.
        addr[3] = fresh_address();
        insert(addr[3], random_line());
        fetch(addr[1], 1'b0);
        fetch(addr[2], 1'b0);
        fetch(addr[3], 1'b0);

        fetch(addr[3], 1'b1);
        fetch(addr[3], 1'b0);
        addr[4] = fresh_address();
        insert(addr[4], random_line());
        fetch(addr[4], 1'b0);

        addr[5] = fresh_address();
        evict_and_fetch(addr[4], 1'b1, addr[5], random_line());
        fetch(addr[4], 1'b0);
        fetch(addr[5], 1'b0);

        // the address matches, but without lookup_valid nothing is returned.
        mem_address = addr[5];
        tick();
        tick();
        fetch(fresh_address(), 1'b0);

        for (int n = 0; n < 200; n++) begin
            op = $urandom_range(6, 0);
            w  = way_t'($urandom_range(1, 0));
            if (!ref_valid[w]) begin
                w = ~w;
            end
            if (!ref_valid[w] && op != 2) begin
                op = 0;
            end
            case (op)
                0: insert(fresh_address(), random_line());
                1: fetch(stored_address(w), 1'b0);
                2: fetch(fresh_address(), 1'b0);
                3: fetch(stored_address(w), 1'b1);
                4: evict_and_fetch(stored_address(w), 1'b1, fresh_address(), random_line());
                5: begin
                    mem_address = stored_address(w);
                    tick();
                end
                default: evict_and_fetch(stored_address(w), 1'b0, fresh_address(), random_line());
            endcase
        end

        tick();
        tick();
        $display("RESULT: PASS");
        $finish;
    end

endmodule : tb_icache_victim_buffer
